// File: src/riscv_mem_pkg.sv
`default_nettype none

package riscv_mem_pkg;

    // Byte lanes in one 32-bit data word
    localparam int LANES = 4;

    // funct3 of RV32 loads, instr[14:12]
    typedef enum logic [2:0] {
        LB  = 3'b000,  // Signed byte
        LH  = 3'b001,  // Signed halfword
        LW  = 3'b010,  // Word
        LBU = 3'b100,  // Unsigned byte
        LHU = 3'b101   // Unsigned halfword
    } mem_funct3_e;

    // Stores share the size codes of the signed loads
    localparam mem_funct3_e SB = LB;
    localparam mem_funct3_e SH = LH;
    localparam mem_funct3_e SW = LW;

    // One data word seen as a whole, as halfwords or as bytes
    typedef union packed {
        logic [31:0]                  word;
        logic [1:0][15:0]             half;   // half[1] is bits 31:16
        logic [LANES-1:0][7:0]        bytes;  // bytes[0] is the lowest address
    } mem_word_u;

endpackage

`default_nettype wire

// File: src/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

    // Number of sets in each of the two ways
    localparam int SETS_DEF      = 64;

    // log2 of the words per cache line
    localparam int LINE_POW2_DEF = 2;

    // Word address width of the backing RAM
    localparam int AW_DEF        = 12;

endpackage

`default_nettype wire

// File: src/load_format.sv
`timescale 1ns/1ps
`default_nettype none

module load_format (
    input  wire riscv_mem_pkg::mem_word_u   ram_data_i,   // Word read from the cache
    input  wire logic [1:0]                 byte_off_i,   // Byte address bits 1:0
    input  wire riscv_mem_pkg::mem_funct3_e funct3_i,     // Load type
    output logic [31:0]                     load_data_o   // Register-ready value
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = ram_data_i.bytes[byte_off_i];
    assign sel_half = ram_data_i.half[byte_off_i[1]];  // Bit 0 ignored, halfwords aligned

    always_comb begin
        case (funct3_i)
            riscv_mem_pkg::LB: begin
                load_data_o = {{24{sel_byte[7]}}, sel_byte};
            end
            riscv_mem_pkg::LBU: begin
                load_data_o = {24'h000000, sel_byte};
            end
            riscv_mem_pkg::LH: begin
                load_data_o = {{16{sel_half[15]}}, sel_half};
            end
            riscv_mem_pkg::LHU: begin
                load_data_o = {16'h0000, sel_half};
            end
            default: begin
                load_data_o = ram_data_i.word;  // LW
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/store_format.sv
`timescale 1ns/1ps
`default_nettype none

module store_format (
    input  wire logic [31:0]                      store_data_i,  // rs2 value
    input  wire logic [1:0]                       byte_off_i,    // Byte address bits 1:0
    input  wire logic [1:0]                       size_i,        // funct3[1:0]
    output logic [31:0]                           lane_data_o,   // Data placed on its lanes
    output logic [riscv_mem_pkg::LANES-1:0]       lane_we_o      // Byte-lane enables
);

    localparam int LN = riscv_mem_pkg::LANES;

    localparam logic [1:0] SIZE_B = 2'(riscv_mem_pkg::SB);
    localparam logic [1:0] SIZE_H = 2'(riscv_mem_pkg::SH);
    localparam logic [1:0] SIZE_W = 2'(riscv_mem_pkg::SW);

    localparam logic [LN-1:0] BYTE_WE = 1;  // Lane 0 only
    localparam logic [LN-1:0] HALF_WE = 3;  // Lanes 1:0

    always_comb begin
        case (size_i)
            SIZE_B: begin
                lane_data_o = {LN{store_data_i[7:0]}};
                lane_we_o   = BYTE_WE << byte_off_i;
            end
            SIZE_H: begin
                lane_data_o = {(LN/2){store_data_i[15:0]}};
                lane_we_o   = HALF_WE << {byte_off_i[1], 1'b0};
            end
            SIZE_W: begin
                lane_data_o = store_data_i;
                lane_we_o   = '1;
            end
            default: begin
                lane_data_o = store_data_i;  // Illegal size writes nothing
                lane_we_o   = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/two_way_set_assoc_cache_wt.sv
`timescale 1ns/1ps
`default_nettype none

module two_way_set_assoc_cache_wt #(
    parameter int SETS      = cache_cfg_pkg::SETS_DEF,
    parameter int LINE_POW2 = cache_cfg_pkg::LINE_POW2_DEF,
    parameter int AW        = cache_cfg_pkg::AW_DEF
) (
    input  wire logic                              cpu_clock_i,
    input  wire logic                              reset_i,

    input  wire logic [AW+1:0]                     cpu_addr_i,       // Byte address
    input  wire logic [31:0]                       cpu_data_i,       // Store data
    input  wire logic [2:0]                        cpu_mem_ctrl_i,   // funct3
    input  wire logic                              cpu_mem_write_i,  // High for stores
    input  wire logic                              cpu_valid_i,      // Access in this cycle

    input  wire logic                              wb_stall_i,
    input  wire logic                              wb_ack_i,
    input  wire logic [31:0]                       wb_dat_i,         // Fill data

    output logic [31:0]                            cpu_data_o,       // Formatted load data
    output logic                                   cpu_stall_o,      // Hold the pipeline

    output logic                                   wb_cyc_o,
    output logic                                   wb_stb_o,
    output logic                                   wb_we_o,
    output logic [AW-1:0]                          wb_adr_o,         // Word address
    output logic [31:0]                            wb_dat_o,
    output logic [riscv_mem_pkg::LANES-1:0]        wb_sel_o
);

    localparam int LN    = riscv_mem_pkg::LANES;
    localparam int SET_W = $clog2(SETS);
    localparam int TAG_W = AW - SET_W - LINE_POW2;
    localparam int IDX_W = 1 + SET_W + LINE_POW2;         // {way, set, word}
    localparam int CNT_W = (LINE_POW2 > 0) ? LINE_POW2 : 1;

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(2**LINE_POW2 - 1);
    localparam logic [AW-1:0]    OFF_MASK = AW'(2**LINE_POW2 - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,  // Single write-through cycle
        ST_FILL    // Line burst after a read miss
    } state_e;

    state_e            state;

    logic [31:0]       data_ram [2**IDX_W];
    logic [TAG_W-1:0]  tag0 [SETS];
    logic [TAG_W-1:0]  tag1 [SETS];
    logic [SETS-1:0]   valid0;
    logic [SETS-1:0]   valid1;
    logic [SETS-1:0]   mru;       // Way of the last read hit
    logic [CNT_W-1:0]  fill_cnt;  // Words received in the current fill

    logic [AW-1:0]     cpu_word;
    logic [SET_W-1:0]  cpu_set;
    logic [TAG_W-1:0]  cpu_tag;
    logic [1:0]        cpu_match;
    logic              hit;
    logic              repl_way;

    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  fill_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic [LN-1:0]     wr_en;
    logic [31:0]       wr_data;

    riscv_mem_pkg::mem_word_u   ram_word;
    riscv_mem_pkg::mem_funct3_e load_funct3;
    logic [31:0]       lane_data;
    logic [LN-1:0]     lane_we;

    logic              accept;
    logic              write_ack;
    logic              fill_ack;
    logic              fill_last;
    logic              issue_last;
    logic              start_write;
    logic              start_fill;
    logic              read_hit;

    assign cpu_word = cpu_addr_i[AW+1:2];
    assign cpu_set  = cpu_word[LINE_POW2 +: SET_W];
    assign cpu_tag  = cpu_word[AW-1 -: TAG_W];

    assign cpu_match[0] = valid0[cpu_set] && (tag0[cpu_set] == cpu_tag);
    assign cpu_match[1] = valid1[cpu_set] && (tag1[cpu_set] == cpu_tag);
    assign hit          = |cpu_match;

    // Invalid way first, way 1 preferred, else the LRU way
    assign repl_way = (valid0[cpu_set] && valid1[cpu_set]) ? ~mru[cpu_set] : ~valid1[cpu_set];

    assign accept      = wb_stb_o && !wb_stall_i;
    assign write_ack   = (state == ST_WRITE) && wb_ack_i;
    assign fill_ack    = (state == ST_FILL) && wb_ack_i;
    assign fill_last   = (fill_cnt == CNT_LAST);
    assign issue_last  = (LINE_POW2 == 0) || (wb_adr_o[CNT_W-1:0] == CNT_LAST);
    assign start_write = (state == ST_IDLE) && cpu_valid_i && cpu_mem_write_i;
    assign start_fill  = (state == ST_IDLE) && cpu_valid_i && !cpu_mem_write_i && !hit;
    assign read_hit    = cpu_valid_i && !cpu_mem_write_i && hit;

    // Stores wait for their ack, loads for a hit
    assign cpu_stall_o = cpu_valid_i && (cpu_mem_write_i ? !write_ack : !hit);

    assign rd_idx   = {cpu_match[1], cpu_word[IDX_W-2:0]};
    assign fill_idx = (IDX_W'({repl_way, cpu_set}) << LINE_POW2) | IDX_W'(fill_cnt);
    assign wr_idx   = (state == ST_FILL) ? fill_idx : rd_idx;
    assign wr_data  = (state == ST_FILL) ? wb_dat_i : lane_data;
    assign wr_en    = (state == ST_FILL) ? {LN{wb_ack_i}} : (lane_we & {LN{write_ack && hit}});

    assign ram_word    = data_ram[rd_idx];
    assign load_funct3 = riscv_mem_pkg::mem_funct3_e'(cpu_mem_ctrl_i);

    load_format load_fmt_inst (
        .ram_data_i  (ram_word),
        .byte_off_i  (cpu_addr_i[1:0]),
        .funct3_i    (load_funct3),
        .load_data_o (cpu_data_o)
    );

    store_format store_fmt_inst (
        .store_data_i (cpu_data_i),
        .byte_off_i   (cpu_addr_i[1:0]),
        .size_i       (cpu_mem_ctrl_i[1:0]),
        .lane_data_o  (lane_data),
        .lane_we_o    (lane_we)
    );

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            state    <= ST_IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
            fill_cnt <= '0;
            valid0   <= '0;
            valid1   <= '0;
            mru      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_write) begin
                        state    <= ST_WRITE;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= 1'b1;
                    end else if (start_fill) begin
                        state    <= ST_FILL;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= 1'b0;
                    end else if (read_hit) begin
                        mru[cpu_set] <= cpu_match[1];
                    end
                end
                ST_WRITE: begin
                    if (accept) begin
                        wb_stb_o <= 1'b0;
                    end
                    if (wb_ack_i) begin
                        state    <= ST_IDLE;
                        wb_cyc_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                    end
                end
                ST_FILL: begin
                    if (accept && issue_last) begin
                        wb_stb_o <= 1'b0;  // Whole line requested
                    end
                    if (wb_ack_i) begin
                        if (fill_last) begin
                            state    <= ST_IDLE;
                            wb_cyc_o <= 1'b0;
                            fill_cnt <= '0;
                            if (repl_way) begin
                                valid1[cpu_set] <= 1'b1;
                            end else begin
                                valid0[cpu_set] <= 1'b1;
                            end
                        end else begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (start_write) begin
            wb_adr_o <= cpu_word;
            wb_dat_o <= lane_data;
            wb_sel_o <= lane_we;
        end else if (start_fill) begin
            wb_adr_o <= cpu_word & ~OFF_MASK;  // Line base
            wb_sel_o <= '1;
        end else if ((state == ST_FILL) && accept && !issue_last) begin
            wb_adr_o <= wb_adr_o + 1'b1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (fill_ack && fill_last) begin
            if (repl_way) begin
                tag1[cpu_set] <= cpu_tag;
            end else begin
                tag0[cpu_set] <= cpu_tag;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        for (int k = 0; k < LN; k++) begin
            if (wr_en[k]) begin
                data_ram[wr_idx][k*8 +: 8] <= wr_data[k*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/wb_wait_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_wait_ram #(
    parameter int AW          = cache_cfg_pkg::AW_DEF,
    parameter int WAIT_STATES = 0
) (
    input  wire logic                              cpu_clock_i,
    input  wire logic                              reset_i,
    input  wire logic                              wb_cyc_i,
    input  wire logic                              wb_stb_i,
    input  wire logic                              wb_we_i,
    input  wire logic [AW-1:0]                     wb_adr_i,  // Word address
    input  wire logic [31:0]                       wb_dat_i,
    input  wire logic [riscv_mem_pkg::LANES-1:0]   wb_sel_i,
    output logic                                   wb_ack_o,
    output logic                                   wb_stall_o,
    output logic [31:0]                            wb_dat_o
);

    localparam int LN    = riscv_mem_pkg::LANES;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]       mem [2**AW];

    logic              busy;      // Holding a request
    logic [CNT_W-1:0]  wait_cnt;  // Cycles left before the ack
    logic              accept;

    logic [AW-1:0]     req_adr;
    logic [31:0]       req_dat;
    logic [LN-1:0]     req_sel;
    logic              req_we;

    initial begin
        for (int i = 0; i < 2**AW; i++) begin
            mem[i] = '0;
        end
    end

    assign wb_ack_o   = busy && (wait_cnt == '0);
    assign wb_stall_o = busy && (wait_cnt != '0);  // Free again in the ack cycle
    assign accept     = wb_cyc_i && wb_stb_i && !wb_stall_o;
    assign wb_dat_o   = mem[req_adr];

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            wait_cnt <= CNT_W'(WAIT_STATES);
        end else if (wb_ack_o) begin
            busy     <= 1'b0;
        end else if (busy) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (accept) begin
            req_adr <= wb_adr_i;
            req_dat <= wb_dat_i;
            req_sel <= wb_sel_i;
            req_we  <= wb_we_i;
        end
    end

    // Write lands with the ack
    always_ff @(posedge cpu_clock_i) begin
        if (wb_ack_o && req_we) begin
            for (int k = 0; k < LN; k++) begin
                if (req_sel[k]) begin
                    mem[req_adr][k*8 +: 8] <= req_dat[k*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem #(
    parameter int SETS        = cache_cfg_pkg::SETS_DEF,
    parameter int LINE_POW2   = cache_cfg_pkg::LINE_POW2_DEF,
    parameter int AW          = cache_cfg_pkg::AW_DEF,
    parameter int WAIT_STATES = 2
) (
    input  wire logic              cpu_clock_i,
    input  wire logic              reset_i,
    input  wire logic [AW+1:0]     cpu_addr_i,
    input  wire logic [31:0]       cpu_data_i,
    input  wire logic [2:0]        cpu_mem_ctrl_i,
    input  wire logic              cpu_mem_write_i,
    input  wire logic              cpu_valid_i,
    output logic [31:0]            cpu_data_o,
    output logic                   cpu_stall_o
);

    logic                              wb_cyc;
    logic                              wb_stb;
    logic                              wb_we;
    logic [AW-1:0]                     wb_adr;
    logic [31:0]                       wb_dat_w;  // Cache to RAM
    logic [31:0]                       wb_dat_r;  // RAM to cache
    logic [riscv_mem_pkg::LANES-1:0]   wb_sel;
    logic                              wb_ack;
    logic                              wb_stall;

    two_way_set_assoc_cache_wt #(
        .SETS      (SETS),
        .LINE_POW2 (LINE_POW2),
        .AW        (AW)
    ) cache_inst (
        .cpu_clock_i     (cpu_clock_i),
        .reset_i         (reset_i),
        .cpu_addr_i      (cpu_addr_i),
        .cpu_data_i      (cpu_data_i),
        .cpu_mem_ctrl_i  (cpu_mem_ctrl_i),
        .cpu_mem_write_i (cpu_mem_write_i),
        .cpu_valid_i     (cpu_valid_i),
        .wb_stall_i      (wb_stall),
        .wb_ack_i        (wb_ack),
        .wb_dat_i        (wb_dat_r),
        .cpu_data_o      (cpu_data_o),
        .cpu_stall_o     (cpu_stall_o),
        .wb_cyc_o        (wb_cyc),
        .wb_stb_o        (wb_stb),
        .wb_we_o         (wb_we),
        .wb_adr_o        (wb_adr),
        .wb_dat_o        (wb_dat_w),
        .wb_sel_o        (wb_sel)
    );

    wb_wait_ram #(
        .AW          (AW),
        .WAIT_STATES (WAIT_STATES)
    ) ram_inst (
        .cpu_clock_i (cpu_clock_i),
        .reset_i     (reset_i),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_w),
        .wb_sel_i    (wb_sel),
        .wb_ack_o    (wb_ack),
        .wb_stall_o  (wb_stall),
        .wb_dat_o    (wb_dat_r)
    );

endmodule

`default_nettype wire

// File: dv/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int AW         = cache_cfg_pkg::AW_DEF;
    localparam int SETS       = cache_cfg_pkg::SETS_DEF;
    localparam int LINE_WORDS = 2**cache_cfg_pkg::LINE_POW2_DEF;
    localparam int BUS_WAIT   = 2;    // Wait states of the default backing RAM
    localparam int PERIOD     = 8;
    localparam int DIRECTED   = 67;   // Loads and stores of the directed phases
    localparam int RANDOM_OPS = 400;
    localparam int TIMEOUT    = (DIRECTED + RANDOM_OPS) * (LINE_WORDS + 2) * (BUS_WAIT + 2) + 200;

    logic            cpu_clock_i     = 1'b0;
    logic            reset_i         = 1'b1;
    logic [AW+1:0]   cpu_addr_i      = '0;
    logic [31:0]     cpu_data_i      = '0;
    logic [2:0]      cpu_mem_ctrl_i  = '0;
    logic            cpu_mem_write_i = 1'b0;
    logic            cpu_valid_i     = 1'b0;
    logic [31:0]     cpu_data_o;
    logic            cpu_stall_o;

    logic [31:0]     shadow [2**AW];  // Expected memory contents
    integer          seed = 22;

    dcache_subsystem dcache_subsystem_inst (
        .cpu_clock_i     (cpu_clock_i),
        .reset_i         (reset_i),
        .cpu_addr_i      (cpu_addr_i),
        .cpu_data_i      (cpu_data_i),
        .cpu_mem_ctrl_i  (cpu_mem_ctrl_i),
        .cpu_mem_write_i (cpu_mem_write_i),
        .cpu_valid_i     (cpu_valid_i),
        .cpu_data_o      (cpu_data_o),
        .cpu_stall_o     (cpu_stall_o)
    );

    always #(PERIOD/2) cpu_clock_i = ~cpu_clock_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic logic [AW+1:0] make_addr(input int tag_no, input int set_no,
                                                input int word_no, input int off);
        int byte_addr;
        byte_addr = ((tag_no * SETS + set_no) * LINE_WORDS + word_no) * 4 + off;
        return byte_addr[AW+1:0];
    endfunction

    // Expected register value of a load from one memory word
    function automatic logic [31:0] ref_load(input logic [31:0] mem_word, input logic [1:0] off,
                                             input logic [2:0] f3);
        riscv_mem_pkg::mem_word_u w;
        logic [7:0]  b;
        logic [15:0] h;
        w.word = mem_word;
        b = w.bytes[off];
        h = w.half[off[1]];
        case (f3)
            riscv_mem_pkg::LB:  return {{24{b[7]}}, b};
            riscv_mem_pkg::LBU: return {24'h000000, b};
            riscv_mem_pkg::LH:  return {{16{h[15]}}, h};
            riscv_mem_pkg::LHU: return {16'h0000, h};
            default:            return w.word;
        endcase
    endfunction

    task automatic shadow_store(input logic [AW+1:0] addr, input logic [2:0] f3,
                                input logic [31:0] data);
        riscv_mem_pkg::mem_word_u w;
        w.word = shadow[addr[AW+1:2]];
        case (f3)
            riscv_mem_pkg::SB: w.bytes[addr[1:0]] = data[7:0];
            riscv_mem_pkg::SH: w.half[addr[1]]    = data[15:0];
            default:           w.word             = data;
        endcase
        shadow[addr[AW+1:2]] = w.word;
    endtask

    // Present one access and hold it until the stall drops
    task automatic run_op(input logic wr, input logic [2:0] f3, input logic [AW+1:0] addr,
                          input logic [31:0] data, output int stalls);
        logic done;
        @(negedge cpu_clock_i);
        cpu_valid_i     = 1'b1;
        cpu_mem_write_i = wr;
        cpu_mem_ctrl_i  = f3;
        cpu_addr_i      = addr;
        cpu_data_i      = data;
        stalls = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge cpu_clock_i);
            if (cpu_stall_o) begin
                stalls++;
            end else begin
                done = 1'b1;
            end
        end
        if (wr) begin
            shadow_store(addr, f3, data);  // Store completed in this cycle
        end
    endtask

    task automatic load_check(input logic [AW+1:0] addr, input logic [2:0] f3, input logic missed);
        int stalls;
        run_op(1'b0, f3, addr, 32'h0, stalls);
        assert ((stalls > 0) == missed) else begin
            abort_run($sformatf("Load at address %h %s", addr, missed ?
                      "returned without the expected miss" : "stalled although the line was cached"));
        end
    endtask

    always @(posedge cpu_clock_i) begin : compare_loads
        logic [31:0] exp_data;
        if (!reset_i && cpu_valid_i && !cpu_mem_write_i && !cpu_stall_o) begin
            exp_data = ref_load(shadow[cpu_addr_i[AW+1:2]], cpu_addr_i[1:0], cpu_mem_ctrl_i);
            assert (cpu_data_o === exp_data) else begin
                abort_run($sformatf("ERR cpu_data_o got %h expected %h at address %h",
                                    cpu_data_o, exp_data, cpu_addr_i));
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT) @(posedge cpu_clock_i);
        abort_run("Watchdog expired because the cache stalled forever");
    end

    initial begin : stimulus
        int            stalls;
        logic [AW+1:0] addr;
        logic [AW+1:0] wa_c;
        logic [AW+1:0] wa_u;
        logic [31:0]   rnd;
        logic [31:0]   data;
        logic [2:0]    f3;
        logic [1:0]    off;
        logic [31:0]   pattern [2];
        for (int k = 0; k < 2**AW; k++) begin
            shadow[k] = '0;
        end
        pattern[0] = 32'h80FF_7F81;
        pattern[1] = 32'hFE01_8000;
        repeat (5) @(negedge cpu_clock_i);
        reset_i = 1'b0;
        repeat (4) begin
            @(posedge cpu_clock_i);
            assert (!cpu_stall_o) else begin
                abort_run("Stall was raised after reset with no access presented");
            end
        end
        for (int k = 0; k < 4; k++) begin
            load_check(make_addr(k, 9 * k, k, 0), riscv_mem_pkg::LW, 1'b1);  // Cold lines
        end
        // Every load type at every legal offset
        for (int w = 0; w < 2; w++) begin
            run_op(1'b1, riscv_mem_pkg::SW, make_addr(1, 1, w, 0), pattern[w], stalls);
        end
        for (int w = 0; w < 2; w++) begin
            for (int o = 0; o < 4; o++) begin
                addr = make_addr(1, 1, w, o);
                run_op(1'b0, riscv_mem_pkg::LB, addr, 32'h0, stalls);
                run_op(1'b0, riscv_mem_pkg::LBU, addr, 32'h0, stalls);
                if (o % 2 == 0) begin
                    run_op(1'b0, riscv_mem_pkg::LH, addr, 32'h0, stalls);
                    run_op(1'b0, riscv_mem_pkg::LHU, addr, 32'h0, stalls);
                end
                if (o == 0) begin
                    run_op(1'b0, riscv_mem_pkg::LW, addr, 32'h0, stalls);
                end
            end
        end
        wa_c = make_addr(1, 2, 1, 0);
        wa_u = make_addr(1, 3, 2, 0);
        load_check(wa_c, riscv_mem_pkg::LW, 1'b1);
        for (int o = 0; o < 4; o++) begin
            run_op(1'b1, riscv_mem_pkg::SB, wa_c + o, 32'h1234_56A0 + o, stalls);
            run_op(1'b1, riscv_mem_pkg::SB, wa_u + o, 32'h89AB_CDE0 + o, stalls);
        end
        load_check(wa_c, riscv_mem_pkg::LW, 1'b0);  // Updated in place
        load_check(wa_u, riscv_mem_pkg::LW, 1'b1);  // Store miss allocated nothing
        wa_u = make_addr(2, 3, 0, 0);
        for (int o = 0; o < 4; o += 2) begin
            run_op(1'b1, riscv_mem_pkg::SH, wa_c + o, 32'h0F0F_80F1 + o, stalls);
            run_op(1'b1, riscv_mem_pkg::SH, wa_u + o, 32'h5A5A_C3C0 + o, stalls);
        end
        load_check(wa_c, riscv_mem_pkg::LW, 1'b0);
        load_check(wa_u, riscv_mem_pkg::LW, 1'b1);
        for (int o = 0; o < 4; o++) begin
            load_check(wa_c + o, riscv_mem_pkg::LBU, 1'b0);
        end
        load_check(make_addr(2, 2, 0, 0), riscv_mem_pkg::LW, 1'b1);
        load_check(make_addr(3, 2, 0, 0), riscv_mem_pkg::LW, 1'b1);  // Evicts wa_c
        load_check(wa_c, riscv_mem_pkg::LW, 1'b1);
        // Whole line present after one fill
        load_check(make_addr(3, 4, 0, 0), riscv_mem_pkg::LW, 1'b1);
        for (int w = 1; w < LINE_WORDS; w++) begin
            load_check(make_addr(3, 4, w, 0), riscv_mem_pkg::LW, 1'b0);
        end
        load_check(make_addr(1, 5, 0, 0), riscv_mem_pkg::LW, 1'b1);  // A
        load_check(make_addr(2, 5, 0, 0), riscv_mem_pkg::LW, 1'b1);  // B
        load_check(make_addr(1, 5, 0, 0), riscv_mem_pkg::LW, 1'b0);  // A becomes MRU
        load_check(make_addr(3, 5, 0, 0), riscv_mem_pkg::LW, 1'b1);  // C replaces B
        load_check(make_addr(1, 5, 0, 0), riscv_mem_pkg::LW, 1'b0);
        load_check(make_addr(3, 5, 0, 0), riscv_mem_pkg::LW, 1'b0);
        load_check(make_addr(2, 5, 0, 0), riscv_mem_pkg::LW, 1'b1);
        // Random mix over four tags and four sets
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd  = $random(seed);
            data = $random(seed);
            case (rnd[20:18])
                3'd0:    f3 = riscv_mem_pkg::LB;
                3'd1:    f3 = riscv_mem_pkg::LBU;
                3'd2:    f3 = riscv_mem_pkg::LH;
                3'd3:    f3 = riscv_mem_pkg::LHU;
                3'd4:    f3 = riscv_mem_pkg::LW;
                3'd5:    f3 = riscv_mem_pkg::SB;
                3'd6:    f3 = riscv_mem_pkg::SH;
                default: f3 = riscv_mem_pkg::SW;
            endcase
            off  = (f3[1:0] == 2'b00) ? rnd[17:16] : ((f3[1:0] == 2'b01) ? {rnd[17], 1'b0} : 2'b00);
            addr = make_addr(rnd[1:0], rnd[3:2], rnd[15:4] % LINE_WORDS, off);
            run_op(rnd[20:18] >= 3'd5, f3, addr, data, stalls);
        end
        @(negedge cpu_clock_i);
        cpu_valid_i = 1'b0;
        repeat (2) @(posedge cpu_clock_i);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_subsystem.f
src/riscv_mem_pkg.sv
src/cache_cfg_pkg.sv
src/load_format.sv
src/store_format.sv
src/two_way_set_assoc_cache_wt.sv
src/wb_wait_ram.sv
src/dcache_subsystem.sv
dv/dcache_tb.sv
